// ==== tests/exec_cases.txt ====
# name op pc a b c tag ill mis / value we jump target code addr rd strb wdata / stall
# all hex except the stall count; code 1f means no trap
add      ADD    100 5 7 0 0 0 0 c 1 0 100 1f c 0 0 0 0
sub      SUB    104 5 7 0 0 0 0 fffffffe 1 0 104 1f c 0 0 0 0
xor      XOR    108 f0f0 ff00 0 0 0 0 ff0 1 0 108 1f 1eff0 0 0 0 0
and      AND    110 f0f0 ff00 0 0 0 0 f000 1 0 110 1f 1eff0 0 0 0 1
sll      SLL    114 1 24 0 0 0 0 10 1 0 114 1f 24 0 0 0 0
srl      SRL    118 80000000 3f 0 0 0 0 1 1 0 118 1f 8000003c 0 0 0 0
sra      SRA    11c 80000000 4 0 0 0 0 f8000000 1 0 11c 1f 80000004 0 0 0 0
slt      SLT    120 ffffffff 1 0 0 0 0 1 1 0 120 1f 0 0 0 0 0
sltu     SLTU   124 ffffffff 1 0 0 0 0 0 1 0 124 1f 0 0 0 0 3
lui      LUI    128 0 12345000 0 0 0 0 12345000 1 0 128 1f 12345000 0 0 0 0
lw       LW     12c 1000 8 0 0 0 0 1008 1 0 12c 1f 1008 1 0 0 1
sb       SB     134 2000 1 a5 0 0 0 a5 0 0 1d9 1f 2000 0 2 a5a5a5a5 2
sh       SH     138 2000 2 1234beef 0 0 0 1234beef 0 0 1234c027 1f 2000 0 c beefbeef 0
sw       SW     13c 2000 4 cafef00d 0 0 0 cafef00d 0 0 cafef149 1f 2004 0 f cafef00d 1
beq_nt   BEQ    200 1 2 10 0 0 0 3 0 0 210 1f 0 0 0 10 0
blt_tk   BLT    204 fffffffe 1 20 0 0 0 ffffffff 0 1 224 1f fffffffc 0 0 20 2
kill_add ADD    208 1 1 0 0 0 0 2 0 0 208 1f 0 0 0 0 0
kill_sw  SW     20c 3000 0 11 0 0 0 11 0 0 21d 1f 3000 0 0 11 0
new_add  ADD    300 2 3 0 1 0 0 5 1 0 300 1f 4 0 0 0 0
jal      JAL    304 304 100 0 1 0 0 308 1 1 404 1f 404 0 0 0 0
jalr     JALR   404 1001 4 0 2 0 0 408 1 1 1004 1f 1004 0 0 0 1
bgeu_tk  BGEU   500 5 5 fffffff0 3 0 0 a 0 1 4f0 1f 8 0 0 fffffff0 0
ecall    ECALL  600 0 0 0 4 0 0 0 0 0 600 b 0 0 0 0 0
ebreak   EBREAK 604 0 0 0 5 0 0 0 0 0 604 3 0 0 0 0 1
ill_mis  ECALL  608 0 0 0 6 1 1 0 0 0 608 2 0 0 0 0 0
mis_jal  JAL    60c 60c 2 0 7 0 1 610 0 0 60e 0 60c 0 0 0 0
kill_ebk EBREAK 700 0 0 0 7 0 0 0 0 0 700 1f 0 0 0 0 0
wrap_add ADD    704 7 9 0 0 0 0 10 1 0 704 1f 10 0 0 0 0

// ==== sources.f ====
+incdir+include
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/branch_unit.sv
rtl/store_request.sv
rtl/trap_tag_ctrl.sv
rtl/execute_stage.sv
tests/tb_execute.sv

// ==== Bender.yml ====
package:
  name: execute_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/exec_pkg.sv
      - rtl/exec_alu.sv
      - rtl/branch_unit.sv
      - rtl/store_request.sv
      - rtl/trap_tag_ctrl.sv
      - rtl/execute_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_execute.sv

// ==== tests/tb_execute.sv ====
// Run from the project root so tests/exec_cases.txt is found; stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module tb_execute
    import exec_pkg::*;
();

    localparam int TIMEOUT = 50;
    localparam int MAX_GAP = 2;

    logic      clk;
    logic      reset;
    issue_t    issue;
    logic      issue_valid;
    logic      issue_ready;
    result_t   result;
    logic      result_valid;
    logic      result_ready;
    mem_req_t  mem_req;
    redirect_t redirect;
    logic      killed;

    // Reference flow tag stepping on every expected jump or trap
    logic [`EXEC_TAG_W-1:0] tag_model;

    execute_stage i_dut (
        .clk            (clk),
        .reset          (reset),
        .issue_i        (issue),
        .issue_valid_i  (issue_valid),
        .issue_ready_o  (issue_ready),
        .result_o       (result),
        .result_valid_o (result_valid),
        .result_ready_i (result_ready),
        .mem_req_o      (mem_req),
        .redirect_o     (redirect),
        .killed_o       (killed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s result: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s mem_req: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp,
                                  input redirect_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s redirect: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_kill(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s killed: expected %b actual %b", name, exp, act));
        end
    endtask

    // Maps the mnemonic in the case file onto the operation enum
    function automatic logic find_op(input string s, output op_e op);
        op_e probe;
        int  idx;
        find_op = 1'b0;
        op = NOP;
        probe = probe.first();
        for (idx = 0; idx < probe.num(); idx++) begin
            if (probe.name() == s) begin
                op = probe;
                find_op = 1'b1;
            end
            probe = probe.next();
        end
    endfunction

    ////////////////////////////////
    // Handshake helpers
    ////////////////////////////////

    task automatic wait_issue_ready(input string name);
        int cycles;
        cycles = 0;
        while (issue_ready !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                fail_run($sformatf("Case %s: issue_ready_o never rose, the item was not accepted",
                                   name));
            end
            @(negedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic wait_result_taken(input string name);
        int cycles;
        cycles = 0;
        do begin
            if (cycles == TIMEOUT) begin
                fail_run($sformatf("Case %s: result_valid_o never fell, the result was not taken",
                                   name));
            end
            @(posedge clk);
            #1;
            cycles++;
        end while (result_valid !== 1'b0);
    endtask

    task automatic run_case(input string name, input issue_t item, input result_t exp_res,
                            input mem_req_t exp_mem, input redirect_t exp_red, input int stalls);
        mem_req_t  idle_mem;
        redirect_t idle_red;
        logic      exp_kill;
        int        gap;
        idle_mem = exp_mem;
        idle_mem.read_enable = 1'b0;
        idle_mem.write_strobe = '0;
        idle_red = exp_red;
        idle_red.jump = 1'b0;
        idle_red.trap = 1'b0;
        idle_red.code = NONE;
        exp_kill = item.tag != tag_model;

        @(negedge clk);
        issue = item;
        issue_valid = 1'b1;
        result_ready = 1'b1;
        #1;
        wait_issue_ready(name);
        // Transfer cycle
        if (result_valid !== 1'b0) begin
            fail_run($sformatf("Case %s: result_valid_o was high before the transfer", name));
        end
        check_kill(name, exp_kill, killed);
        check_mem(name, exp_mem, mem_req);
        check_redirect(name, exp_red, redirect);
        @(posedge clk);
        if (exp_red.jump || exp_red.trap) begin
            tag_model = tag_model + 1'b1;
        end

        // Same item stays offered while stalled and must not transfer
        @(negedge clk);
        issue_valid = stalls > 0;
        result_ready = stalls == 0;
        #1;
        if (result_valid !== 1'b1) begin
            fail_run($sformatf("Case %s: result_valid_o did not rise one clock after transfer",
                               name));
        end
        check_result(name, exp_res, result);
        for (gap = 0; gap < stalls; gap++) begin
            if (issue_ready !== 1'b0) begin
                fail_run($sformatf("Case %s: issue_ready_o stayed high with result stalled", name));
            end
            if (result_valid !== 1'b1) begin
                fail_run($sformatf("Case %s: result_valid_o dropped before result was taken", name));
            end
            check_mem(name, idle_mem, mem_req);
            check_redirect(name, idle_red, redirect);
            check_result(name, exp_res, result);
            @(negedge clk);
            if (gap == stalls - 1) begin
                issue_valid = 1'b0;
                result_ready = 1'b1;
            end
            #1;
        end
        wait_result_taken(name);
    endtask

    ////////////////////////////////
    // Case file driver
    ////////////////////////////////

    initial begin
        int          fd;
        int          fields;
        int          count;
        int          stall;
        string       line;
        string       name;
        string       op_name;
        op_e         op;
        logic [31:0] pc, a, b, c, tag, ill, mis;
        logic [31:0] value, we, jmp, target, code, addr, rd, strb, wdata;
        issue_t      item;
        result_t     exp_res;
        mem_req_t    exp_mem;
        redirect_t   exp_red;

        void'($urandom(61));
        reset = 1'b1;
        issue = '0;
        issue_valid = 1'b0;
        result_ready = 1'b0;
        tag_model = '0;
        count = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("tests/exec_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open tests/exec_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                             name, op_name, pc, a, b, c, tag, ill, mis,
                             value, we, jmp, target, code, addr, rd, strb, wdata, stall);
            if (fields != 19) begin
                fail_run($sformatf("Malformed line in the case file: %s", line));
            end
            if (!find_op(op_name, op)) begin
                fail_run($sformatf("Unknown operation %s in case %s", op_name, name));
            end
            item.op = op;
            item.pc = pc;
            item.operand_a = a;
            item.operand_b = b;
            item.operand_c = c;
            item.tag = tag[`EXEC_TAG_W-1:0];
            item.exc_illegal = ill[0];
            item.exc_misaligned = mis[0];
            exp_res.op = op;
            exp_res.value = value;
            exp_res.write_enable = we[0];
            exp_mem.address = addr;
            exp_mem.read_enable = rd[0];
            exp_mem.write_strobe = strb[`EXEC_STRB_W-1:0];
            exp_mem.write_data = wdata;
            exp_red.jump = jmp[0];
            exp_red.target = target;
            exp_red.code = exc_code_e'(code[4:0]);
            exp_red.trap = exp_red.code != NONE;
            run_case(name, item, exp_res, exp_mem, exp_red, stall + ($urandom % (MAX_GAP + 1)));
            count++;
        end
        $fclose(fd);

        if (count == 0) begin
            fail_run("The case file held no cases");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// Single result slot; mem_req_o and redirect_o are combinational and valid only in the fire cycle
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module execute_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  issue_t    issue_i,
    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    output result_t   result_o,
    output logic      result_valid_o,
    input  logic      result_ready_i,
    output mem_req_t  mem_req_o,
    output redirect_t redirect_o,
    output logic      killed_o
);

    logic [`EXEC_XLEN-1:0] alu_value;
    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] target;
    logic                  taken;
    logic                  fire;
    logic                  killed;
    logic                  jump;
    logic                  trap;
    logic                  no_write;
    exc_code_e             code;
    result_t               result_d;

    ////////////////////////////////
    // Handshake
    ////////////////////////////////

    // Slot frees up in the same cycle the consumer takes it
    assign issue_ready_o = !result_valid_o || result_ready_i;
    assign fire          = issue_valid_i && issue_ready_o;

    ////////////////////////////////
    // Datapath
    ////////////////////////////////

    exec_alu i_alu (
        .op_i        (issue_i.op),
        .pc_i        (issue_i.pc),
        .operand_a_i (issue_i.operand_a),
        .operand_b_i (issue_i.operand_b),
        .operand_c_i (issue_i.operand_c),
        .value_o     (alu_value),
        .sum_o       (sum)
    );

    branch_unit i_branch (
        .op_i        (issue_i.op),
        .pc_i        (issue_i.pc),
        .operand_a_i (issue_i.operand_a),
        .operand_b_i (issue_i.operand_b),
        .operand_c_i (issue_i.operand_c),
        .sum_i       (sum),
        .taken_o     (taken),
        .target_o    (target)
    );

    store_request i_store (
        .op_i        (issue_i.op),
        .operand_c_i (issue_i.operand_c),
        .sum_i       (sum),
        .fire_i      (fire),
        .killed_i    (killed),
        .mem_req_o   (mem_req_o)
    );

    // Tag advances once whether jump, trap or both fire
    assign jump = taken && fire && !killed;

    trap_tag_ctrl i_trap_tag (
        .clk              (clk),
        .reset            (reset),
        .op_i             (issue_i.op),
        .tag_i            (issue_i.tag),
        .exc_illegal_i    (issue_i.exc_illegal),
        .exc_misaligned_i (issue_i.exc_misaligned),
        .fire_i           (fire),
        .jump_i           (jump),
        .killed_o         (killed),
        .trap_o           (trap),
        .code_o           (code)
    );

    assign killed_o = killed;

    always_comb begin
        redirect_o.jump   = jump && !trap;
        redirect_o.target = target;
        redirect_o.trap   = trap;
        redirect_o.code   = code;
    end

    ////////////////////////////////
    // Result register
    ////////////////////////////////

    assign no_write = issue_i.op inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU,
                                         ECALL, EBREAK};

    always_comb begin
        result_d.op           = issue_i.op;
        result_d.value        = alu_value;
        result_d.write_enable = !(no_write || killed || trap);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
        end else if (fire) begin
            result_valid_o <= 1'b1;
        end else if (result_ready_i) begin
            result_valid_o <= 1'b0;
        end
    end

    // Result payload loaded on each transfer
    always_ff @(posedge clk) begin
        if (fire) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/trap_tag_ctrl.sv ====
// jump_i must already be qualified by fire and not-killed; one tag step per redirect
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module trap_tag_ctrl
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  op_e                    op_i,
    input  logic [`EXEC_TAG_W-1:0] tag_i,
    input  logic                   exc_illegal_i,
    input  logic                   exc_misaligned_i,
    input  logic                   fire_i,
    input  logic                   jump_i,
    output logic                   killed_o,
    output logic                   trap_o,
    output exc_code_e              code_o
);

    logic [`EXEC_TAG_W-1:0] curr_tag;
    logic                   live;

    ////////////////////////////////
    // Kill decision
    ////////////////////////////////

    // Items fetched before the last redirect carry a stale tag
    assign killed_o = curr_tag != tag_i;
    assign live     = fire_i && !killed_o;

    ////////////////////////////////
    // Exception priority
    ////////////////////////////////

    always_comb begin
        trap_o = live;
        if (exc_illegal_i) begin
            code_o = ILLEGAL_INSTRUCTION;
        end else if (exc_misaligned_i) begin
            code_o = INSTRUCTION_ADDRESS_MISALIGNED;
        end else if (op_i == ECALL) begin
            code_o = ECALL_FROM_MMODE;
        end else if (op_i == EBREAK) begin
            code_o = BREAKPOINT;
        end else begin
            trap_o = 1'b0;
            code_o = NONE;
        end
        if (!trap_o) begin
            code_o = NONE;
        end
    end

    ////////////////////////////////
    // Flow tag
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_i || trap_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/store_request.sv ====
// Word-aligned requests only; misaligned halfword or word stores are not trapped here
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module store_request
    import exec_pkg::*;
(
    input  op_e                   op_i,
    input  logic [`EXEC_XLEN-1:0] operand_c_i,
    input  logic [`EXEC_XLEN-1:0] sum_i,
    input  logic                  fire_i,
    input  logic                  killed_i,
    output mem_req_t              mem_req_o
);

    logic                    enable;
    logic                    is_load;
    logic [`EXEC_STRB_W-1:0] strobe;

    // Only a live transfer may touch memory
    assign enable  = fire_i && !killed_i;
    assign is_load = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////
    // Byte strobe
    ////////////////////////////////

    always_comb begin
        unique case (op_i)
            SB:      strobe = `EXEC_STRB_BYTE0 << sum_i[1:0];
            SH:      strobe = sum_i[1] ? `EXEC_STRB_HIGH_HALF : `EXEC_STRB_LOW_HALF;
            SW:      strobe = `EXEC_STRB_ALL;
            default: strobe = `EXEC_STRB_NONE;
        endcase
    end

    ////////////////////////////////
    // Request
    ////////////////////////////////

    always_comb begin
        mem_req_o.address      = {sum_i[`EXEC_XLEN-1:2], 2'b00};
        mem_req_o.read_enable  = is_load && enable;
        mem_req_o.write_strobe = enable ? strobe : `EXEC_STRB_NONE;
        // Lane replication lets memory pick bytes by strobe alone
        unique case (op_i)
            SB:      mem_req_o.write_data = {4{operand_c_i[7:0]}};
            SH:      mem_req_o.write_data = {2{operand_c_i[15:0]}};
            default: mem_req_o.write_data = operand_c_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
// Combinational; JAL expects pc in operand a, JALR expects rs1, both with the offset in operand b
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module branch_unit
    import exec_pkg::*;
(
    input  op_e                   op_i,
    input  logic [`EXEC_XLEN-1:0] pc_i,
    input  logic [`EXEC_XLEN-1:0] operand_a_i,
    input  logic [`EXEC_XLEN-1:0] operand_b_i,
    input  logic [`EXEC_XLEN-1:0] operand_c_i,
    input  logic [`EXEC_XLEN-1:0] sum_i,
    output logic                  taken_o,
    output logic [`EXEC_XLEN-1:0] target_o
);

    logic signed [`EXEC_XLEN-1:0] a_signed;
    logic signed [`EXEC_XLEN-1:0] b_signed;
    logic                         equal;
    logic                         less;
    logic                         less_unsigned;

    assign a_signed      = operand_a_i;
    assign b_signed      = operand_b_i;
    assign equal         = operand_a_i == operand_b_i;
    assign less          = a_signed < b_signed;
    assign less_unsigned = operand_a_i < operand_b_i;

    // Condition per branch type
    always_comb begin
        unique case (op_i)
            BEQ:       taken_o = equal;
            BNE:       taken_o = !equal;
            BLT:       taken_o = less;
            BLTU:      taken_o = less_unsigned;
            BGE:       taken_o = !less;
            BGEU:      taken_o = !less_unsigned;
            JAL, JALR: taken_o = 1'b1;
            default:   taken_o = 1'b0;
        endcase
    end

    // Branch offset comes in operand c
    always_comb begin
        unique case (op_i)
            JAL:     target_o = sum_i;
            JALR:    target_o = {sum_i[`EXEC_XLEN-1:1], 1'b0};
            default: target_o = pc_i + operand_c_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_alu.sv ====
// Purely combinational; stores return operand c, other ops without a result of their own return a+b
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module exec_alu
    import exec_pkg::*;
(
    input  op_e                   op_i,
    input  logic [`EXEC_XLEN-1:0] pc_i,
    input  logic [`EXEC_XLEN-1:0] operand_a_i,
    input  logic [`EXEC_XLEN-1:0] operand_b_i,
    input  logic [`EXEC_XLEN-1:0] operand_c_i,
    output logic [`EXEC_XLEN-1:0] value_o,
    output logic [`EXEC_XLEN-1:0] sum_o
);

    logic signed [`EXEC_XLEN-1:0] a_signed;
    logic signed [`EXEC_XLEN-1:0] b_signed;
    logic [`EXEC_SHAMT_W-1:0]     shamt;
    logic [`EXEC_XLEN-1:0]        diff;
    logic [`EXEC_XLEN-1:0]        link;
    logic                         lt_signed;
    logic                         lt_unsigned;

    assign a_signed = operand_a_i;
    assign b_signed = operand_b_i;
    assign shamt    = operand_b_i[`EXEC_SHAMT_W-1:0];

    ////////////////////////////////
    // Arithmetic
    ////////////////////////////////

    // Shared with the address path and the JAL/JALR targets
    assign sum_o = operand_a_i + operand_b_i;
    assign diff  = operand_a_i - operand_b_i;
    assign link  = pc_i + `EXEC_LINK_OFFSET;

    assign lt_signed   = a_signed < b_signed;
    assign lt_unsigned = operand_a_i < operand_b_i;

    ////////////////////////////////
    // Result select
    ////////////////////////////////

    always_comb begin
        unique case (op_i)
            SUB:       value_o = diff;
            SLT:       value_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            SLTU:      value_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            XOR:       value_o = operand_a_i ^ operand_b_i;
            OR:        value_o = operand_a_i | operand_b_i;
            AND:       value_o = operand_a_i & operand_b_i;
            SLL:       value_o = operand_a_i << shamt;
            SRL:       value_o = operand_a_i >> shamt;
            SRA:       value_o = a_signed >>> shamt;
            // Immediate arrives already shifted in operand b
            LUI:       value_o = operand_b_i;
            JAL, JALR: value_o = link;
            // Store data passed through for observation only
            SB, SH, SW: value_o = operand_c_i;
            default:   value_o = sum_o;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
// Exception codes follow the RISC-V mcause numbering; NONE uses a reserved code
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    ////////////////////////////////
    // Encodings
    ////////////////////////////////

    typedef enum logic [5:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR,
        ECALL, EBREAK, NOP
    } op_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        ECALL_FROM_MMODE               = 5'd11,
        NONE                           = 5'd31
    } exc_code_e;

    ////////////////////////////////
    // Interface bundles
    ////////////////////////////////

    // Decoded instruction as it leaves the operand fetch
    typedef struct packed {
        op_e                    op;
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  operand_a;
        logic [`EXEC_XLEN-1:0]  operand_b;
        logic [`EXEC_XLEN-1:0]  operand_c;
        logic [`EXEC_TAG_W-1:0] tag;
        logic                   exc_illegal;
        logic                   exc_misaligned;
    } issue_t;

    typedef struct packed {
        op_e                    op;
        logic [`EXEC_XLEN-1:0]  value;
        logic                   write_enable;
    } result_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]   address;
        logic                    read_enable;
        logic [`EXEC_STRB_W-1:0] write_strobe;
        logic [`EXEC_XLEN-1:0]   write_data;
    } mem_req_t;

    // Flow change towards fetch, trap wins over jump
    typedef struct packed {
        logic                  jump;
        logic [`EXEC_XLEN-1:0] target;
        logic                  trap;
        exc_code_e             code;
    } redirect_t;

endpackage

`default_nettype wire

// ==== include/exec_consts.svh ====
// Widths fixed for RV32I with a 3-bit flow tag; the strobe patterns assume a 4-byte data bus
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

////////////////////////////////
// Datapath widths
////////////////////////////////

// Register and address width
`define EXEC_XLEN 32

// Flow tag, wraps after 8 redirects
`define EXEC_TAG_W 3

// Shift amount taken from the low bits of operand b
`define EXEC_SHAMT_W 5

// Return address increment for JAL and JALR
`define EXEC_LINK_OFFSET 32'd4

////////////////////////////////
// Byte strobe patterns
////////////////////////////////

`define EXEC_STRB_W 4
`define EXEC_STRB_NONE 4'b0000
`define EXEC_STRB_BYTE0 4'b0001
`define EXEC_STRB_LOW_HALF 4'b0011
`define EXEC_STRB_HIGH_HALF 4'b1100
`define EXEC_STRB_ALL 4'b1111

`endif
